/* files.f */
hw/march_pkg.sv
hw/ray_job_if.sv
hw/march_cfg_regs.sv
hw/pixel_dispatch.sv
hw/ray_core.sv
hw/ray_marcher_top.sv
tb/tb_ray_marcher.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ray marcher testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module tb_ray_marcher -o sim_ray_marcher
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_ray_marcher > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
exit 0

/* tb/tb_ray_marcher.sv */
`timescale 1ns/1ps

module tb_ray_marcher;

  localparam int WIDTH             = march_pkg::DISPLAY_WIDTH;
  localparam int NUM_PIXELS        = march_pkg::DISPLAY_WIDTH * march_pkg::DISPLAY_HEIGHT;
  localparam int SURFACE_BASE      = 64;
  localparam int HANDSHAKE_TIMEOUT = 20;
  localparam int START_TIMEOUT     = 100;
  localparam int FRAME_TIMEOUT     = 2000;
  localparam int QUIET_CYCLES      = 60;

  localparam logic [7:0] CTRL_ENABLE = 8'h01;

  logic                 clk_in;
  logic                 rst_in;
  logic                 cfg_req;
  march_pkg::cfg_addr_t cfg_addr;
  logic [7:0]           cfg_data;
  logic                 cfg_ack;
  logic                 pix_valid;
  march_pkg::hcount_t   pix_hcount;
  march_pkg::vcount_t   pix_vcount;
  march_pkg::color_t    pix_color;
  logic                 new_frame;

  // capture of the current frame, filled by the monitor
  int nf_count;
  int pix_total;
  int seen_count [NUM_PIXELS];
  int got_color  [NUM_PIXELS];
  int mon_idx;

  int          error_count;
  int          check_count;
  string       current_test;
  logic [31:0] lfsr_state;

  ray_marcher_top dut (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .cfg_req    (cfg_req),
    .cfg_addr   (cfg_addr),
    .cfg_data   (cfg_data),
    .cfg_ack    (cfg_ack),
    .pix_valid  (pix_valid),
    .pix_hcount (pix_hcount),
    .pix_vcount (pix_vcount),
    .pix_color  (pix_color),
    .new_frame  (new_frame)
  );

  initial begin
    clk_in = 1'b0;
    forever #10 clk_in = ~clk_in;
  end

  // sample outputs shortly after each edge
  always begin
    @(posedge clk_in);
    #1;
    if (!rst_in) begin
      if (new_frame) begin
        nf_count++;
      end
      if (pix_valid) begin
        if (nf_count == 0) begin
          error_count++;
          $display("pixel (%0d,%0d) arrived before new_frame in %s",
                   pix_hcount, pix_vcount, current_test);
        end
        mon_idx = int'(pix_vcount) * WIDTH + int'(pix_hcount);
        seen_count[mon_idx]++;
        got_color[mon_idx] = int'(pix_color);
        pix_total++;
      end
    end
  end

  // right-shifting galois lfsr, one step per bit
  function automatic int rand_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
      r = (r << 1) | int'(lfsr_state[0]);
    end
    return r;
  endfunction

  // march rule: count steps until the surface or the step limit
  function automatic int expected_color(input int origin, input int step, input int scene,
                                        input int h, input int v);
    int surface;
    int pos;
    int n;
    surface = SURFACE_BASE;
    case (scene)
      1: surface = SURFACE_BASE + 8 * ((h + v) % 4);
      2: surface = SURFACE_BASE + 4 * h;
      3: surface = ((h % 2) != (v % 2)) ? SURFACE_BASE + 16 : SURFACE_BASE;
      default: surface = SURFACE_BASE;
    endcase
    pos = origin;
    n = 0;
    while (pos < surface && n < march_pkg::MAX_STEPS) begin
      pos = (pos + step > 255) ? 255 : pos + step;
      n++;
    end
    return n;
  endfunction

  function automatic logic [7:0] ctrl_value(input int scene, input bit checker_on);
    return {4'b0000, 2'(scene), checker_on, 1'b0};
  endfunction

  task automatic finish_run();
    $display("checks run: %0d, errors counted: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  task automatic fail_timeout(input string what);
    error_count++;
    $display("timeout in %s: %s", current_test, what);
    finish_run();
  endtask

  task automatic clear_capture();
    nf_count  = 0;
    pix_total = 0;
    for (int i = 0; i < NUM_PIXELS; i++) begin
      seen_count[i] = 0;
      got_color[i]  = 0;
    end
  endtask

  // four-phase write, ack expected one cycle after each req edge
  task automatic cfg_write(input march_pkg::cfg_addr_t addr, input logic [7:0] data);
    int cycles;
    check_count++;
    if (cfg_ack !== 1'b0) begin
      error_count++;
      $display("cfg_ack high before req in %s", current_test);
    end
    cfg_addr = addr;
    cfg_data = data;
    cfg_req  = 1'b1;
    cycles = 0;
    while (cfg_ack !== 1'b1) begin
      if (cycles == HANDSHAKE_TIMEOUT) begin
        fail_timeout("cfg_ack never rose");
      end
      @(posedge clk_in);
      #2;
      cycles++;
    end
    check_count++;
    if (cycles != 1) begin
      error_count++;
      $display("mismatch %s ack rise delay: expected 1, actual %0d", current_test, cycles);
    end
    cfg_req = 1'b0;
    cycles = 0;
    while (cfg_ack !== 1'b0) begin
      if (cycles == HANDSHAKE_TIMEOUT) begin
        fail_timeout("cfg_ack never fell");
      end
      @(posedge clk_in);
      #2;
      cycles++;
    end
    check_count++;
    if (cycles != 1) begin
      error_count++;
      $display("mismatch %s ack fall delay: expected 1, actual %0d", current_test, cycles);
    end
  endtask

  // nothing may come out while enable is off
  task automatic check_quiet(input int cycles);
    int start_pix;
    int start_nf;
    start_pix = pix_total;
    start_nf  = nf_count;
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk_in);
      #2;
    end
    check_count++;
    if (pix_total != start_pix || nf_count != start_nf) begin
      error_count++;
      $display("output activity in %s while frame enable was off", current_test);
    end
  endtask

  // run exactly one frame and gather its pixels
  task automatic collect_frame(input logic [7:0] ctrl, input int expected,
                               input bit change_origin, input logic [7:0] new_origin);
    int cycles;
    clear_capture();
    cfg_write(march_pkg::CFG_CTRL, ctrl | CTRL_ENABLE);
    cycles = 0;
    while (nf_count == 0) begin
      if (cycles == START_TIMEOUT) begin
        fail_timeout("no new_frame after enable");
      end
      @(posedge clk_in);
      #2;
      cycles++;
    end
    cfg_write(march_pkg::CFG_CTRL, ctrl & ~CTRL_ENABLE);
    if (change_origin) begin
      check_count++;
      if (pix_total >= expected) begin
        error_count++;
        $display("origin write in %s landed after the frame had finished", current_test);
      end
      cfg_write(march_pkg::CFG_ORIGIN, new_origin);
    end
    cycles = 0;
    while (pix_total < expected) begin
      if (cycles == FRAME_TIMEOUT) begin
        fail_timeout("frame did not deliver all pixels");
      end
      @(posedge clk_in);
      #2;
      cycles++;
    end
    check_quiet(QUIET_CYCLES);
    check_count++;
    if (pix_total != expected) begin
      error_count++;
      $display("mismatch %s pixel total: expected %0d, actual %0d",
               current_test, expected, pix_total);
    end
    check_count++;
    if (nf_count != 1) begin
      error_count++;
      $display("mismatch %s new_frame pulses: expected 1, actual %0d", current_test, nf_count);
    end
  endtask

  task automatic check_frame(input int origin, input int step, input int scene,
                             input bit checker_on, input int parity);
    int h;
    int v;
    int want;
    for (int i = 0; i < NUM_PIXELS; i++) begin
      h = i % WIDTH;
      v = i / WIDTH;
      check_count++;
      if (!checker_on || ((h + v) % 2) == parity) begin
        want = expected_color(origin, step, scene, h, v);
        if (seen_count[i] != 1) begin
          error_count++;
          $display("mismatch %s pixel (%0d,%0d) count: expected 1, actual %0d",
                   current_test, h, v, seen_count[i]);
        end else if (got_color[i] != want) begin
          error_count++;
          $display("mismatch %s pixel (%0d,%0d) colour: expected %0d, actual %0d",
                   current_test, h, v, want, got_color[i]);
        end
      end else if (seen_count[i] != 0) begin
        error_count++;
        $display("mismatch %s skipped pixel (%0d,%0d) count: expected 0, actual %0d",
                 current_test, h, v, seen_count[i]);
      end
    end
  endtask

  task automatic test_register_handshake();
    current_test = "register_handshake";
    check_count++;
    if (cfg_ack !== 1'b0 || pix_valid !== 1'b0 || new_frame !== 1'b0) begin
      error_count++;
      $display("outputs not low after reset");
    end
    cfg_write(march_pkg::CFG_ORIGIN, 8'd20);
    cfg_write(march_pkg::CFG_STEP, 8'd5);
    cfg_write(march_pkg::CFG_CTRL, 8'h00);
    check_quiet(QUIET_CYCLES);
  endtask

  task automatic test_scene0_frame();
    current_test = "scene0_frame";
    cfg_write(march_pkg::CFG_ORIGIN, 8'd20);
    cfg_write(march_pkg::CFG_STEP, 8'd5);
    collect_frame(ctrl_value(0, 1'b0), NUM_PIXELS, 1'b0, 8'd0);
    check_frame(20, 5, 0, 1'b0, 0);
  endtask

  task automatic test_surface_scenes();
    int origin;
    int step;
    for (int scene = 1; scene < 4; scene++) begin
      current_test = $sformatf("surface_scene%0d", scene);
      origin = rand_bits(6);
      step   = 1 + rand_bits(3);
      cfg_write(march_pkg::CFG_ORIGIN, 8'(origin));
      cfg_write(march_pkg::CFG_STEP, 8'(step));
      collect_frame(ctrl_value(scene, 1'b0), NUM_PIXELS, 1'b0, 8'd0);
      check_frame(origin, step, scene, 1'b0, 0);
    end
    // unit step from far below, runs into the step limit
    current_test = "surface_step_limit";
    origin = rand_bits(5);
    cfg_write(march_pkg::CFG_ORIGIN, 8'(origin));
    cfg_write(march_pkg::CFG_STEP, 8'd1);
    collect_frame(ctrl_value(2, 1'b0), NUM_PIXELS, 1'b0, 8'd0);
    check_frame(origin, 1, 2, 1'b0, 0);
  endtask

  task automatic test_checker_frames();
    int parity;
    current_test = "checker_frame_a";
    cfg_write(march_pkg::CFG_ORIGIN, 8'd30);
    cfg_write(march_pkg::CFG_STEP, 8'd4);
    collect_frame(ctrl_value(1, 1'b1), NUM_PIXELS / 2, 1'b0, 8'd0);
    parity = -1;
    for (int i = 0; i < NUM_PIXELS; i++) begin
      if (parity < 0 && seen_count[i] > 0) begin
        parity = ((i % WIDTH) + (i / WIDTH)) % 2;
      end
    end
    if (parity < 0) begin
      error_count++;
      $display("no pixel seen in the first checker frame");
      parity = 0;
    end
    check_frame(30, 4, 1, 1'b1, parity);
    current_test = "checker_frame_b";
    collect_frame(ctrl_value(1, 1'b1), NUM_PIXELS / 2, 1'b0, 8'd0);
    check_frame(30, 4, 1, 1'b1, 1 - parity);
  endtask

  task automatic test_param_latching();
    current_test = "latch_old_origin";
    cfg_write(march_pkg::CFG_ORIGIN, 8'd10);
    cfg_write(march_pkg::CFG_STEP, 8'd6);
    collect_frame(ctrl_value(3, 1'b0), NUM_PIXELS, 1'b1, 8'd50);
    check_frame(10, 6, 3, 1'b0, 0);
    current_test = "latch_new_origin";
    collect_frame(ctrl_value(3, 1'b0), NUM_PIXELS, 1'b0, 8'd0);
    check_frame(50, 6, 3, 1'b0, 0);
  endtask

  initial begin
    rst_in       = 1'b1;
    cfg_req      = 1'b0;
    cfg_addr     = '0;
    cfg_data     = '0;
    error_count  = 0;
    check_count  = 0;
    lfsr_state   = 32'h8ea;
    current_test = "reset";
    clear_capture();
    repeat (16) @(posedge clk_in);
    #2;
    rst_in = 1'b0;
    test_register_handshake();
    test_scene0_frame();
    test_surface_scenes();
    test_checker_frames();
    test_param_latching();
    current_test = "idle_after_frames";
    check_quiet(QUIET_CYCLES);
    finish_run();
  end

endmodule

/* hw/ray_marcher_top.sv */
`timescale 1ns/1ps

module ray_marcher_top (
  input  logic                 clk_in,
  input  logic                 rst_in,
  input  logic                 cfg_req,
  input  march_pkg::cfg_addr_t cfg_addr,
  input  logic [7:0]           cfg_data,
  output logic                 cfg_ack,
  output logic                 pix_valid,
  output march_pkg::hcount_t   pix_hcount,
  output march_pkg::vcount_t   pix_vcount,
  output march_pkg::color_t    pix_color,
  output logic                 new_frame
);

  march_pkg::height_t origin;
  march_pkg::step_t   step;
  march_pkg::scene_t  scene;
  logic               frame_en;
  logic               checker_en;

  // one job channel per core
  ray_job_if job_bus [march_pkg::NUM_CORES] ();

  march_cfg_regs u_cfg_regs (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .cfg_req    (cfg_req),
    .cfg_addr   (cfg_addr),
    .cfg_data   (cfg_data),
    .cfg_ack    (cfg_ack),
    .origin     (origin),
    .step       (step),
    .scene      (scene),
    .frame_en   (frame_en),
    .checker_en (checker_en)
  );

  pixel_dispatch u_dispatch (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .origin     (origin),
    .step       (step),
    .scene      (scene),
    .frame_en   (frame_en),
    .checker_en (checker_en),
    .jobs       (job_bus),
    .pix_valid  (pix_valid),
    .pix_hcount (pix_hcount),
    .pix_vcount (pix_vcount),
    .pix_color  (pix_color),
    .new_frame  (new_frame)
  );

  for (genvar g = 0; g < march_pkg::NUM_CORES; g++) begin : g_cores
    ray_core u_core (
      .clk_in (clk_in),
      .rst_in (rst_in),
      .job    (job_bus[g])
    );
  end

endmodule

/* hw/ray_core.sv */
`timescale 1ns/1ps

module ray_core (
  input  logic    clk_in,
  input  logic    rst_in,
  ray_job_if.core job
);

  march_pkg::core_state_t state;
  march_pkg::height_t     pos;
  march_pkg::height_t     surface;
  march_pkg::height_t     surface_next;
  march_pkg::color_t      count;
  march_pkg::hcount_t     pix_h;
  march_pkg::vcount_t     pix_v;
  logic [1:0]             diag;
  logic [8:0]             pos_sum;
  logic                   hit;
  logic                   take_job;

  // low two bits of hcount plus vcount
  assign diag = job.job_hcount[1:0] + job.job_vcount;

  // surface height for the offered pixel
  always_comb begin
    case (job.scene)
      2'd0: surface_next = march_pkg::SURFACE_BASE;
      2'd1: surface_next = march_pkg::SURFACE_BASE + {3'b000, diag, 3'b000};
      2'd2: surface_next = march_pkg::SURFACE_BASE + {3'b000, job.job_hcount, 2'b00};
      default: begin
        if (job.job_hcount[0] ^ job.job_vcount[0]) begin
          surface_next = march_pkg::SURFACE_BASE + 8'd16;
        end else begin
          surface_next = march_pkg::SURFACE_BASE;
        end
      end
    endcase
  end

  assign take_job = (state == march_pkg::FREE) && job.job_valid;
  assign pos_sum  = {1'b0, pos} + {1'b0, job.step};
  assign hit      = (pos >= surface) || (count == march_pkg::color_t'(march_pkg::MAX_STEPS));

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= march_pkg::FREE;
    end else begin
      case (state)
        march_pkg::FREE: begin
          if (job.job_valid) begin
            state <= march_pkg::MARCH;
          end
        end
        march_pkg::MARCH: begin
          if (hit) begin
            state <= march_pkg::DONE;
          end
        end
        march_pkg::DONE: begin
          if (job.res_taken) begin
            state <= march_pkg::FREE;
          end
        end
        default: begin
          state <= march_pkg::FREE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (take_job) begin
      pix_h   <= job.job_hcount;
      pix_v   <= job.job_vcount;
      pos     <= job.origin;
      count   <= '0;
      surface <= surface_next;
    end else if (state == march_pkg::MARCH && !hit) begin
      // saturate at the top of the height range
      pos   <= pos_sum[8] ? '1 : pos_sum[7:0];
      count <= count + 1'b1;
    end
  end

  assign job.core_free  = state == march_pkg::FREE;
  assign job.res_valid  = state == march_pkg::DONE;
  assign job.res_hcount = pix_h;
  assign job.res_vcount = pix_v;
  assign job.res_color  = count;

  res_held_until_taken: assert property (
    @(posedge clk_in) disable iff (rst_in)
    job.res_valid && !job.res_taken |=> job.res_valid
  );

endmodule

/* hw/pixel_dispatch.sv */
`timescale 1ns/1ps

module pixel_dispatch (
  input  logic               clk_in,
  input  logic               rst_in,
  input  march_pkg::height_t origin,
  input  march_pkg::step_t   step,
  input  march_pkg::scene_t  scene,
  input  logic               frame_en,
  input  logic               checker_en,
  ray_job_if.dispatch        jobs [march_pkg::NUM_CORES],
  output logic               pix_valid,
  output march_pkg::hcount_t pix_hcount,
  output march_pkg::vcount_t pix_vcount,
  output march_pkg::color_t  pix_color,
  output logic               new_frame
);

  march_pkg::dispatch_state_t state;
  march_pkg::core_idx_t       poll_ptr;
  march_pkg::hcount_t         hcount;
  march_pkg::vcount_t         vcount;
  march_pkg::hcount_t         job_hcount;
  march_pkg::vcount_t         job_vcount;
  logic                       all_assigned;
  logic                       phase;

  // frame parameters held for the whole frame
  march_pkg::height_t frame_origin;
  march_pkg::step_t   frame_step;
  march_pkg::scene_t  frame_scene;
  logic               frame_checker;

  logic [march_pkg::NUM_CORES-1:0] job_valid;
  logic [march_pkg::NUM_CORES-1:0] res_taken;
  logic [march_pkg::NUM_CORES-1:0] core_free;
  logic [march_pkg::NUM_CORES-1:0] res_valid;
  march_pkg::hcount_t              res_hcount [march_pkg::NUM_CORES];
  march_pkg::vcount_t              res_vcount [march_pkg::NUM_CORES];
  march_pkg::color_t               res_color  [march_pkg::NUM_CORES];

  logic cores_idle;
  logic poll_free;
  logic poll_done;
  logic render_pix;
  logic last_col;
  logic frame_start;
  logic assign_now;

  for (genvar g = 0; g < march_pkg::NUM_CORES; g++) begin : g_core_bus
    assign jobs[g].job_valid  = job_valid[g];
    assign jobs[g].job_hcount = job_hcount;
    assign jobs[g].job_vcount = job_vcount;
    assign jobs[g].origin     = frame_origin;
    assign jobs[g].step       = frame_step;
    assign jobs[g].scene      = frame_scene;
    assign jobs[g].res_taken  = res_taken[g];
    assign core_free[g]       = jobs[g].core_free;
    assign res_valid[g]       = jobs[g].res_valid;
    assign res_hcount[g]      = jobs[g].res_hcount;
    assign res_vcount[g]      = jobs[g].res_vcount;
    assign res_color[g]       = jobs[g].res_color;

    // a job pulse never lands on a busy core
    job_to_free_core: assert property (
      @(posedge clk_in) disable iff (rst_in)
      job_valid[g] |-> core_free[g]
    );
  end

  // no job in flight and nothing left to collect
  assign cores_idle = (&core_free) && !(|res_valid) && !(|job_valid);
  // skip a core whose job or take pulse is still on its way
  assign poll_free  = core_free[poll_ptr] && !job_valid[poll_ptr];
  assign poll_done  = res_valid[poll_ptr] && !res_taken[poll_ptr];
  // parity of hcount plus vcount is the xor of their low bits
  assign render_pix = !frame_checker || ((hcount[0] ^ vcount[0]) == phase);
  assign last_col   = hcount == march_pkg::hcount_t'(march_pkg::DISPLAY_WIDTH - 1);

  assign frame_start = (state == march_pkg::WAIT_CORES) && frame_en && cores_idle;
  assign assign_now  = (state == march_pkg::ASSIGN) && !all_assigned && poll_free;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state         <= march_pkg::IDLE;
      poll_ptr      <= '0;
      hcount        <= '0;
      vcount        <= '0;
      all_assigned  <= 1'b0;
      phase         <= 1'b0;
      frame_checker <= 1'b0;
      job_valid     <= '0;
      new_frame     <= 1'b0;
    end else begin
      job_valid <= '0;
      new_frame <= 1'b0;
      // round robin, one core per cycle
      if (poll_ptr == march_pkg::core_idx_t'(march_pkg::NUM_CORES - 1)) begin
        poll_ptr <= '0;
      end else begin
        poll_ptr <= poll_ptr + 1'b1;
      end
      case (state)
        march_pkg::IDLE: begin
          if (frame_en) begin
            state <= march_pkg::WAIT_CORES;
          end
        end
        march_pkg::WAIT_CORES: begin
          if (!frame_en) begin
            state <= march_pkg::IDLE;
          end else if (frame_start) begin
            state         <= march_pkg::ASSIGN;
            new_frame     <= 1'b1;
            hcount        <= '0;
            vcount        <= '0;
            all_assigned  <= 1'b0;
            phase         <= ~phase;
            frame_checker <= checker_en;
          end
        end
        march_pkg::ASSIGN: begin
          if (all_assigned) begin
            if (cores_idle) begin
              state <= march_pkg::WAIT_CORES;
            end
          end else if (assign_now) begin
            // a skipped pixel still uses up this slot
            job_valid[poll_ptr] <= render_pix;
            hcount              <= hcount + 1'b1;
            if (last_col) begin
              vcount <= vcount + 1'b1;
            end
            all_assigned <= last_col &&
                            (vcount == march_pkg::vcount_t'(march_pkg::DISPLAY_HEIGHT - 1));
          end
        end
        default: begin
          state <= march_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (frame_start) begin
      frame_origin <= origin;
      frame_step   <= step;
      frame_scene  <= scene;
    end
    if (assign_now) begin
      job_hcount <= hcount;
      job_vcount <= vcount;
    end
  end

  // result collection runs in every state
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pix_valid <= 1'b0;
      res_taken <= '0;
    end else begin
      res_taken <= '0;
      pix_valid <= poll_done;
      if (poll_done) begin
        res_taken[poll_ptr] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (poll_done) begin
      pix_hcount <= res_hcount[poll_ptr];
      pix_vcount <= res_vcount[poll_ptr];
      pix_color  <= res_color[poll_ptr];
    end
  end

  one_job_per_cycle: assert property (
    @(posedge clk_in) disable iff (rst_in)
    $onehot0(job_valid)
  );

endmodule

/* hw/march_cfg_regs.sv */
`timescale 1ns/1ps

module march_cfg_regs (
  input  logic                 clk_in,
  input  logic                 rst_in,
  input  logic                 cfg_req,
  input  march_pkg::cfg_addr_t cfg_addr,
  input  logic [7:0]           cfg_data,
  output logic                 cfg_ack,
  output march_pkg::height_t   origin,
  output march_pkg::step_t     step,
  output march_pkg::scene_t    scene,
  output logic                 frame_en,
  output logic                 checker_en
);

  // cfg_ack doubles as the handshake state bit
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      cfg_ack    <= 1'b0;
      origin     <= '0;
      step       <= '0;
      scene      <= '0;
      frame_en   <= 1'b0;
      checker_en <= 1'b0;
    end else if (cfg_req && !cfg_ack) begin
      // phase 2, write once and acknowledge
      cfg_ack <= 1'b1;
      case (cfg_addr)
        march_pkg::CFG_ORIGIN: begin
          origin <= cfg_data;
        end
        march_pkg::CFG_STEP: begin
          step <= cfg_data;
        end
        march_pkg::CFG_CTRL: begin
          frame_en   <= cfg_data[march_pkg::CTRL_FRAME_EN_BIT];
          checker_en <= cfg_data[march_pkg::CTRL_CHECKER_BIT];
          scene      <= cfg_data[march_pkg::CTRL_SCENE_LSB +: $bits(march_pkg::scene_t)];
        end
        default: begin
          // unmapped address, acknowledged and dropped
        end
      endcase
    end else if (!cfg_req && cfg_ack) begin
      // phase 4, host has released req
      cfg_ack <= 1'b0;
    end
  end

  // ack only answers a request seen on the previous edge
  ack_follows_req: assert property (
    @(posedge clk_in) disable iff (rst_in)
    $rose(cfg_ack) |-> $past(cfg_req)
  );

endmodule

/* hw/ray_job_if.sv */
`timescale 1ns/1ps

interface ray_job_if;

  // job side, frame values stay constant while a frame runs
  logic               job_valid;
  march_pkg::hcount_t job_hcount;
  march_pkg::vcount_t job_vcount;
  march_pkg::height_t origin;
  march_pkg::step_t   step;
  march_pkg::scene_t  scene;
  logic               res_taken;

  // result side
  logic               core_free;
  logic               res_valid;
  march_pkg::hcount_t res_hcount;
  march_pkg::vcount_t res_vcount;
  march_pkg::color_t  res_color;

  modport dispatch (
    output job_valid, job_hcount, job_vcount, origin, step, scene, res_taken,
    input  core_free, res_valid, res_hcount, res_vcount, res_color
  );

  modport core (
    input  job_valid, job_hcount, job_vcount, origin, step, scene, res_taken,
    output core_free, res_valid, res_hcount, res_vcount, res_color
  );

endinterface

/* hw/march_pkg.sv */
package march_pkg;

  // frame geometry
  localparam int DISPLAY_WIDTH  = 8;
  localparam int DISPLAY_HEIGHT = 4;

  localparam int NUM_CORES = 3;

  // march iteration limit, also the brightest colour
  localparam int MAX_STEPS = 15;

  typedef logic [2:0] hcount_t;
  typedef logic [1:0] vcount_t;
  typedef logic [1:0] core_idx_t;
  typedef logic [7:0] height_t;
  typedef logic [7:0] step_t;
  typedef logic [1:0] scene_t;
  typedef logic [3:0] color_t;
  typedef logic [1:0] cfg_addr_t;

  // surface height every scene is built on
  localparam height_t SURFACE_BASE = 8'd64;

  // register map
  localparam cfg_addr_t CFG_ORIGIN = 2'd0;
  localparam cfg_addr_t CFG_STEP   = 2'd1;
  localparam cfg_addr_t CFG_CTRL   = 2'd2;

  // ctrl register fields
  localparam int CTRL_FRAME_EN_BIT = 0;
  localparam int CTRL_CHECKER_BIT  = 1;
  localparam int CTRL_SCENE_LSB    = 2;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_CORES,
    ASSIGN
  } dispatch_state_t;

  typedef enum logic [1:0] {
    FREE,
    MARCH,
    DONE
  } core_state_t;

endpackage
